// File: Makefile
BUILD := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module prf_tb \
		-Mdir $(BUILD) -f compile.f

run: compile
	@out="$$(./$(BUILD)/Vprf_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(BUILD)

// File: bench/prf_tb.sv
module prf_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import rf_cfg_pkg::*;
    import rf_types_pkg::*;

    localparam int n_rd = 2;
    localparam int n_wr = 2;

    // reset cycles plus the length of each test in order plus slack
    localparam int max_cycles = 4 + 17 + 5 + 3 + 3 + 19 + 201 + 100;

    logic                  clk = 1'b0;
    logic                  arst_n;
    logic                  flush;
    wr_port_t [n_wr-1:0]   wr;
    rd_req_t  [n_rd-1:0]   rd_req;
    operand_t [n_rd-1:0]   operand;

    // expected register contents
    rf_data_t              model [rf_entries];

    // expectation for the request issued one cycle earlier
    logic                  pend_on = 1'b0;
    logic                  pend_valid [n_rd];
    rf_data_t              pend_data [n_rd];

    logic [31:0]           lfsr = 32'h92b31b39;
    int                    cycle_count = 0;
    int                    checks = 0;
    int                    errors = 0;

    prf_top #(
        .n_read_ports  (n_rd),
        .n_write_ports (n_wr)
    ) dut0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .wr      (wr),
        .rd_req  (rd_req),
        .operand (operand)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout after %0d cycles, the tests did not finish", cycle_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // galois lfsr stepped once per returned bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic wr_port_t make_write(input logic en, input rf_addr_t a, input rf_data_t d);
        wr_port_t w;
        w.en   = en;
        w.addr = a;
        w.data = d;
        return w;
    endfunction

    function automatic rd_req_t make_read(input logic v, input rf_addr_t a);
        rd_req_t r;
        r.valid = v;
        r.addr  = a;
        return r;
    endfunction

    // flush clears everything, otherwise an entry takes the lowest enabled port
    function automatic void update_model(input wr_port_t [n_wr-1:0] w, input logic f);
        logic lower_hit;
        if (f) begin
            for (int e = 0; e < rf_entries; e++) begin
                model[e] = '0;
            end
        end else begin
            for (int p = 0; p < n_wr; p++) begin
                lower_hit = 1'b0;
                for (int q = 0; q < p; q++) begin
                    if (w[q].en && w[q].addr == w[p].addr) begin
                        lower_hit = 1'b1;
                    end
                end
                if (w[p].en && !lower_hit) begin
                    model[w[p].addr] = w[p].data;
                end
            end
        end
    endfunction

    task automatic check_pending();
        for (int i = 0; i < n_rd; i++) begin
            checks++;
            if (operand[i].valid !== pend_valid[i]) begin
                errors++;
                $display("Fail %0t operand[%0d].valid expected %b got %b",
                         $time, i, pend_valid[i], operand[i].valid);
            end
            if (pend_valid[i] && operand[i].data !== pend_data[i]) begin
                errors++;
                $display("Fail %0t operand[%0d].data expected %h got %h",
                         $time, i, pend_data[i], operand[i].data);
            end
        end
    endtask

    // apply one cycle of inputs and check the previous cycle's operands
    task automatic do_cycle(input wr_port_t [n_wr-1:0] w, input rd_req_t [n_rd-1:0] r,
                            input logic f);
        logic     next_valid [n_rd];
        rf_data_t next_data [n_rd];
        @(posedge clk);
        wr     <= w;
        rd_req <= r;
        flush  <= f;
        update_model(w, f);
        // data seen by a request is the entry after this cycle's writes
        for (int i = 0; i < n_rd; i++) begin
            next_valid[i] = r[i].valid && !f;
            next_data[i]  = model[r[i].addr];
        end
        @(negedge clk);
        if (pend_on) begin
            check_pending();
        end
        pend_on = 1'b1;
        for (int i = 0; i < n_rd; i++) begin
            pend_valid[i] = next_valid[i];
            pend_data[i]  = next_data[i];
        end
    endtask

    task automatic idle_cycle();
        do_cycle('0, '0, 1'b0);
    endtask

    task automatic read_all();
        rd_req_t [n_rd-1:0] r;
        for (int a = 0; a < rf_entries; a += 2) begin
            r[0] = make_read(1'b1, rf_addr_t'(a));
            r[1] = make_read(1'b1, rf_addr_t'(a + 1));
            do_cycle('0, r, 1'b0);
        end
        idle_cycle();
    endtask

    task automatic reset_state();
        @(negedge clk);
        for (int i = 0; i < n_rd; i++) begin
            checks++;
            if (operand[i].valid !== 1'b0) begin
                errors++;
                $display("Fail %0t operand[%0d].valid expected 0 got %b",
                         $time, i, operand[i].valid);
            end
        end
        read_all();
    endtask

    task automatic write_read_back();
        wr_port_t [n_wr-1:0] w;
        rd_req_t  [n_rd-1:0] r;
        w[0] = make_write(1'b1, rf_addr_t'(5), rand_bits(32));
        w[1] = make_write(1'b1, rf_addr_t'(9), rand_bits(32));
        do_cycle(w, '0, 1'b0);
        r[0] = make_read(1'b1, rf_addr_t'(5));
        r[1] = make_read(1'b1, rf_addr_t'(9));
        do_cycle('0, r, 1'b0);
        r[0] = make_read(1'b1, rf_addr_t'(9));
        r[1] = make_read(1'b1, rf_addr_t'(5));
        do_cycle('0, r, 1'b0);
        // neighbours that were never written
        r[0] = make_read(1'b1, rf_addr_t'(6));
        r[1] = make_read(1'b1, rf_addr_t'(0));
        do_cycle('0, r, 1'b0);
        idle_cycle();
    endtask

    task automatic port_collision();
        wr_port_t [n_wr-1:0] w;
        rd_req_t  [n_rd-1:0] r;
        w[0] = make_write(1'b1, rf_addr_t'(12), 32'h0000_aaaa);
        w[1] = make_write(1'b1, rf_addr_t'(12), 32'h0000_bbbb);
        do_cycle(w, '0, 1'b0);
        r[0] = make_read(1'b1, rf_addr_t'(12));
        r[1] = make_read(1'b1, rf_addr_t'(12));
        do_cycle('0, r, 1'b0);
        idle_cycle();
    endtask

    task automatic same_cycle_bypass();
        wr_port_t [n_wr-1:0] w;
        rd_req_t  [n_rd-1:0] r;
        w    = '0;
        w[0] = make_write(1'b1, rf_addr_t'(3), rand_bits(32));
        r[0] = make_read(1'b1, rf_addr_t'(3));
        r[1] = make_read(1'b1, rf_addr_t'(5));
        do_cycle(w, r, 1'b0);
        // both ports hit entry 7 while both reads ask for it
        w[0] = make_write(1'b1, rf_addr_t'(7), 32'h1111_0000);
        w[1] = make_write(1'b1, rf_addr_t'(7), 32'h2222_0000);
        r[0] = make_read(1'b1, rf_addr_t'(7));
        r[1] = make_read(1'b1, rf_addr_t'(7));
        do_cycle(w, r, 1'b0);
        idle_cycle();
    endtask

    task automatic flush_clears_all();
        wr_port_t [n_wr-1:0] w;
        rd_req_t  [n_rd-1:0] r;
        w[0] = make_write(1'b1, rf_addr_t'(14), rand_bits(32));
        w[1] = make_write(1'b1, rf_addr_t'(27), rand_bits(32));
        do_cycle(w, '0, 1'b0);
        w[0] = make_write(1'b1, rf_addr_t'(20), rand_bits(32));
        w[1] = make_write(1'b1, rf_addr_t'(21), rand_bits(32));
        r[0] = make_read(1'b1, rf_addr_t'(14));
        r[1] = make_read(1'b1, rf_addr_t'(20));
        do_cycle(w, r, 1'b1);
        read_all();
    endtask

    task automatic random_traffic();
        wr_port_t [n_wr-1:0] w;
        rd_req_t  [n_rd-1:0] r;
        // narrow address range so collisions and bypass hits are common
        for (int c = 0; c < 200; c++) begin
            for (int p = 0; p < n_wr; p++) begin
                w[p] = make_write(rand_bits(1) != 0, rf_addr_t'(rand_bits(3)), rand_bits(32));
            end
            for (int i = 0; i < n_rd; i++) begin
                r[i] = make_read(rand_bits(1) != 0, rf_addr_t'(rand_bits(3)));
            end
            do_cycle(w, r, 1'b0);
        end
        idle_cycle();
    endtask

    initial begin
        arst_n = 1'b0;
        flush  = 1'b0;
        wr     = '0;
        // reads stay valid during reset so only the reset can hold operand valid low
        rd_req = {n_rd{make_read(1'b1, rf_addr_t'(0))}};
        for (int e = 0; e < rf_entries; e++) begin
            model[e] = '0;
        end
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        rd_req <= '0;

        reset_state();
        write_read_back();
        port_collision();
        same_cycle_bypass();
        flush_clears_all();
        random_traffic();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: common/rf_cfg_pkg.sv
package rf_cfg_pkg;

    // number of physical registers
    parameter int rf_entries = 32;

    // bits held by each register
    parameter int rf_width = 32;

    // address bits needed to select one register
    parameter int rf_ptr_w = $clog2(rf_entries);

endpackage

// File: common/rf_types_pkg.sv
package rf_types_pkg;

    import rf_cfg_pkg::*;

    // physical register address
    typedef logic [rf_ptr_w-1:0] rf_addr_t;

    // physical register data word
    typedef logic [rf_width-1:0] rf_data_t;

    // one writeback port
    typedef struct packed {
        logic     en;
        rf_addr_t addr;
        rf_data_t data;
    } wr_port_t;

    // one read request from the issue side
    typedef struct packed {
        logic     valid;
        rf_addr_t addr;
    } rd_req_t;

    // operand handed to execute, one cycle after the request
    typedef struct packed {
        logic     valid;
        rf_data_t data;
    } operand_t;

endpackage

// File: compile.f
common/rf_cfg_pkg.sv
common/rf_types_pkg.sv
regfile/wr_port_select.sv
regfile/regfile.sv
src/rd_bypass.sv
src/operand_stage.sv
src/prf_top.sv
bench/prf_tb.sv

// File: regfile/regfile.sv
module regfile #(
    parameter int n_read_ports  = 2,
    parameter int n_write_ports = 2
) (
    input  logic                                         clk,
    input  logic                                         arst_n,
    input  logic                                         flush,
    input  rf_types_pkg::wr_port_t [n_write_ports-1:0]   wr,
    input  rf_types_pkg::rf_addr_t [n_read_ports-1:0]    rd_addr,
    output rf_types_pkg::rf_data_t [n_read_ports-1:0]    rd_data
);

    import rf_cfg_pkg::*;
    import rf_types_pkg::*;

    // write decode results, one bit and one word per entry
    logic [rf_entries-1:0]                 entry_we;
    rf_data_t [rf_entries-1:0]             entry_din;

    // register storage
    rf_data_t [rf_entries-1:0]             entries;

    wr_port_select #(
        .n_write_ports (n_write_ports)
    ) wr_sel0 (
        .wr        (wr),
        .entry_we  (entry_we),
        .entry_din (entry_din)
    );

    // flush wins over any write in the same cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            entries <= '0;
        end else if (flush) begin
            entries <= '0;
        end else begin
            for (int e = 0; e < rf_entries; e++) begin
                if (entry_we[e]) begin
                    entries[e] <= entry_din[e];
                end
            end
        end
    end

    // full mux over all entries for each read port
    always_comb begin
        for (int r = 0; r < n_read_ports; r++) begin
            rd_data[r] = '0;
            for (int e = 0; e < rf_entries; e++) begin
                if (rd_addr[r] == rf_addr_t'(e)) begin
                    rd_data[r] = entries[e];
                end
            end
        end
    end

endmodule

// File: regfile/wr_port_select.sv
module wr_port_select #(
    parameter int n_write_ports = 2
) (
    input  rf_types_pkg::wr_port_t [n_write_ports-1:0]        wr,
    output logic [rf_cfg_pkg::rf_entries-1:0]                 entry_we,
    output rf_types_pkg::rf_data_t [rf_cfg_pkg::rf_entries-1:0] entry_din
);

    import rf_cfg_pkg::*;

    // one-hot decode of each port address, gated by its enable
    logic [n_write_ports-1:0][rf_entries-1:0] port_hit;

    always_comb begin
        for (int p = 0; p < n_write_ports; p++) begin
            port_hit[p] = '0;
            if (wr[p].en) begin
                port_hit[p][wr[p].addr] = 1'b1;
            end
        end
    end

    // per-entry enable is the OR over all ports
    // data comes from the lowest-numbered port that hits the entry
    always_comb begin
        for (int e = 0; e < rf_entries; e++) begin
            entry_we[e]  = 1'b0;
            entry_din[e] = '0;
            // walk from the highest port down so port 0 lands last
            for (int p = n_write_ports - 1; p >= 0; p--) begin
                if (port_hit[p][e]) begin
                    entry_we[e]  = 1'b1;
                    entry_din[e] = wr[p].data;
                end
            end
        end
    end

endmodule

// File: src/operand_stage.sv
module operand_stage #(
    parameter int n_read_ports = 2
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       flush,
    input  rf_types_pkg::rd_req_t  [n_read_ports-1:0]  rd_req,
    input  rf_types_pkg::rf_data_t [n_read_ports-1:0]  fwd_data,
    output rf_types_pkg::operand_t [n_read_ports-1:0]  operand
);

    import rf_types_pkg::*;

    logic     [n_read_ports-1:0] valid_q;
    rf_data_t [n_read_ports-1:0] data_q;

    // requests caught by a flush are dropped
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
        end else begin
            for (int r = 0; r < n_read_ports; r++) begin
                valid_q[r] <= rd_req[r].valid && !flush;
            end
        end
    end

    always_ff @(posedge clk) begin
        data_q <= fwd_data;
    end

    always_comb begin
        for (int r = 0; r < n_read_ports; r++) begin
            operand[r].valid = valid_q[r];
            operand[r].data  = data_q[r];
        end
    end

endmodule

// File: src/prf_top.sv
module prf_top #(
    parameter int n_read_ports  = 2,
    parameter int n_write_ports = 2
) (
    input  logic                                       clk,
    input  logic                                       arst_n,
    input  logic                                       flush,
    input  rf_types_pkg::wr_port_t [n_write_ports-1:0] wr,
    input  rf_types_pkg::rd_req_t  [n_read_ports-1:0]  rd_req,
    output rf_types_pkg::operand_t [n_read_ports-1:0]  operand
);

    import rf_types_pkg::*;

    rf_addr_t [n_read_ports-1:0] rd_addr;
    rf_data_t [n_read_ports-1:0] rd_data;
    rf_data_t [n_read_ports-1:0] fwd_data;

    // the storage only needs the address half of each request
    for (genvar r = 0; r < n_read_ports; r++) begin : g_rd_addr
        assign rd_addr[r] = rd_req[r].addr;
    end

    regfile #(
        .n_read_ports  (n_read_ports),
        .n_write_ports (n_write_ports)
    ) regfile0 (
        .clk     (clk),
        .arst_n  (arst_n),
        .flush   (flush),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    rd_bypass #(
        .n_read_ports  (n_read_ports),
        .n_write_ports (n_write_ports)
    ) bypass0 (
        .wr       (wr),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data),
        .fwd_data (fwd_data)
    );

    operand_stage #(
        .n_read_ports (n_read_ports)
    ) opnd0 (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (flush),
        .rd_req   (rd_req),
        .fwd_data (fwd_data),
        .operand  (operand)
    );

endmodule

// File: src/rd_bypass.sv
module rd_bypass #(
    parameter int n_read_ports  = 2,
    parameter int n_write_ports = 2
) (
    input  rf_types_pkg::wr_port_t [n_write_ports-1:0]   wr,
    input  rf_types_pkg::rf_addr_t [n_read_ports-1:0]    rd_addr,
    input  rf_types_pkg::rf_data_t [n_read_ports-1:0]    rd_data,
    output rf_types_pkg::rf_data_t [n_read_ports-1:0]    fwd_data
);

    // address match of every read port against every enabled write port
    logic [n_read_ports-1:0][n_write_ports-1:0] hit;

    always_comb begin
        for (int r = 0; r < n_read_ports; r++) begin
            for (int p = 0; p < n_write_ports; p++) begin
                hit[r][p] = wr[p].en && (wr[p].addr == rd_addr[r]);
            end
        end
    end

    // stored value unless a write in this cycle targets the same entry
    // lowest matching port wins, same rule as the storage itself
    always_comb begin
        for (int r = 0; r < n_read_ports; r++) begin
            fwd_data[r] = rd_data[r];
            for (int p = n_write_ports - 1; p >= 0; p--) begin
                if (hit[r][p]) begin
                    fwd_data[r] = wr[p].data;
                end
            end
        end
    end

endmodule
